/* arch_map.sv */
// committed rename map, one update per retire; entry for r0 never changes
module arch_map (
    input  logic              clock,
    input  logic              reset,
    input  logic              retire_en,
    input  rename_pkg::areg_t retire_areg,
    input  rename_pkg::preg_t retire_tag,
    output rename_pkg::preg_t arch_tags [rename_pkg::NUM_AREGS]
);

    // whole table is visible to the map table for flush recovery
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rename_pkg::NUM_AREGS; i++) begin
                arch_tags[i] <= rename_pkg::reset_map_tag(i);
            end
        end else if (retire_en && (retire_areg != rename_pkg::ZERO_AREG)) begin
            // retiring instruction's tag becomes architectural
            arch_tags[retire_areg] <= retire_tag;
        end
    end

endmodule

/* flist.f */
rename_pkg.sv
reorder_buffer.sv
free_list.sv
map_table.sv
arch_map.sv
rename_core.sv
rename_core_tb.sv

/* free_list.sv */
// circular free tag queue; pop and push only for nonzero destinations, flush restores a full lap
module free_list (
    input  logic              clock,
    input  logic              reset,
    input  logic              alloc_en,
    input  rename_pkg::areg_t dest_reg,
    input  logic              retire_en,
    input  rename_pkg::areg_t retire_areg,
    input  rename_pkg::preg_t freed_tag,
    input  logic              flush,
    output rename_pkg::preg_t front_tag,
    output logic              free_empty
);

    // tag storage, reloaded with the reset mapping
    rename_pkg::preg_t slots [rename_pkg::FREE_SZ];

    // read and write pointers with wrap bit
    rename_pkg::free_ptr_t rd_ptr;
    rename_pkg::free_ptr_t wr_ptr;

    logic pop;
    logic push;

    // r0 neither takes nor returns a tag
    assign pop = alloc_en && (dest_reg != rename_pkg::ZERO_AREG);
    assign push = retire_en && (retire_areg != rename_pkg::ZERO_AREG);

    assign free_empty = (rd_ptr == wr_ptr);

    // tag offered to the current dispatch; r0 sees tag 0
    assign front_tag = (dest_reg == rename_pkg::ZERO_AREG) ? '0
                                                           : slots[rename_pkg::free_slot(rd_ptr)];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rename_pkg::FREE_SZ; i++) begin
                slots[i] <= rename_pkg::reset_free_tag(i);
            end
            rd_ptr <= '0;
            // queue starts full, writer one lap ahead
            wr_ptr <= rename_pkg::free_ptr_t'(rename_pkg::FREE_SZ);
        end else begin
            if (flush) begin
                // popped tags not yet overwritten by a push are exactly
                // the squashed ones, so one lap back recovers them all
                rd_ptr <= wr_ptr ^ rename_pkg::free_ptr_t'(rename_pkg::FREE_SZ);
            end else if (pop) begin
                rd_ptr <= rd_ptr + rename_pkg::free_ptr_t'(1);
            end
            // retire_en is already low during flush
            if (push) begin
                slots[rename_pkg::free_slot(wr_ptr)] <= freed_tag;
                wr_ptr <= wr_ptr + rename_pkg::free_ptr_t'(1);
            end
        end
    end

endmodule

/* map_table.sv */
// speculative rename map; r0 always reads tag 0, flush copies the committed map in one cycle
module map_table (
    input  logic              clock,
    input  logic              reset,
    input  logic              alloc_en,
    input  rename_pkg::areg_t dest_reg,
    input  rename_pkg::preg_t new_tag,
    input  rename_pkg::areg_t src_reg_a,
    input  rename_pkg::areg_t src_reg_b,
    input  logic              flush,
    input  rename_pkg::preg_t arch_tags [rename_pkg::NUM_AREGS],
    output rename_pkg::preg_t src_tag_a,
    output rename_pkg::preg_t src_tag_b,
    output rename_pkg::preg_t old_tag
);

    // newest tag per architectural register
    rename_pkg::preg_t spec_tags [rename_pkg::NUM_AREGS];

    // three combinational lookups, r0 forced to tag 0
    assign src_tag_a = (src_reg_a == rename_pkg::ZERO_AREG) ? '0 : spec_tags[src_reg_a];
    assign src_tag_b = (src_reg_b == rename_pkg::ZERO_AREG) ? '0 : spec_tags[src_reg_b];
    // previous mapping of the destination, stored in the rob for freeing
    assign old_tag = (dest_reg == rename_pkg::ZERO_AREG) ? '0 : spec_tags[dest_reg];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rename_pkg::NUM_AREGS; i++) begin
                spec_tags[i] <= rename_pkg::reset_map_tag(i);
            end
        end else if (flush) begin
            // recovery to the last retired state
            spec_tags <= arch_tags;
        end else if (alloc_en && (dest_reg != rename_pkg::ZERO_AREG)) begin
            spec_tags[dest_reg] <= new_tag;
        end
    end

endmodule

/* rename_core.sv */
// rename and retire top; single dispatch, single retire, flush only at the retire point
module rename_core (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 dispatch_valid,
    input  rename_pkg::areg_t    dest_reg,
    input  rename_pkg::areg_t    src_reg_a,
    input  rename_pkg::areg_t    src_reg_b,
    input  logic                 retire_valid,
    input  logic                 flush,
    output logic                 stall,
    output rename_pkg::preg_t    src_tag_a,
    output rename_pkg::preg_t    src_tag_b,
    output rename_pkg::preg_t    dest_tag,
    output rename_pkg::preg_t    old_tag,
    output rename_pkg::rob_idx_t rob_index,
    output logic                 retire_done,
    output rename_pkg::areg_t    retire_areg,
    output rename_pkg::preg_t    retire_tag,
    output rename_pkg::preg_t    freed_tag,
    output logic                 rob_empty
);

    logic alloc_en;
    logic retire_en;
    logic free_empty;
    rename_pkg::preg_t front_tag;
    rename_pkg::preg_t arch_tags [rename_pkg::NUM_AREGS];

    // front tag is what the rob stores as the new tag, 0 for r0
    assign dest_tag = front_tag;
    assign retire_done = retire_en;

    // acceptance, stall and ordering
    reorder_buffer u_rob (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .flush          (flush),
        .retire_valid   (retire_valid),
        .dest_reg       (dest_reg),
        .new_tag        (front_tag),
        .old_tag_in     (old_tag),
        .free_empty     (free_empty),
        .stall          (stall),
        .alloc_en       (alloc_en),
        .retire_en      (retire_en),
        .rob_index      (rob_index),
        .retire_areg    (retire_areg),
        .retire_tag     (retire_tag),
        .freed_tag      (freed_tag),
        .rob_empty      (rob_empty)
    );

    // popped at dispatch, refilled by retire
    free_list u_free_list (
        .clock       (clock),
        .reset       (reset),
        .alloc_en    (alloc_en),
        .dest_reg    (dest_reg),
        .retire_en   (retire_en),
        .retire_areg (retire_areg),
        .freed_tag   (freed_tag),
        .flush       (flush),
        .front_tag   (front_tag),
        .free_empty  (free_empty)
    );

    // speculative lookups for sources and old destination
    map_table u_map_table (
        .clock     (clock),
        .reset     (reset),
        .alloc_en  (alloc_en),
        .dest_reg  (dest_reg),
        .new_tag   (front_tag),
        .src_reg_a (src_reg_a),
        .src_reg_b (src_reg_b),
        .flush     (flush),
        .arch_tags (arch_tags),
        .src_tag_a (src_tag_a),
        .src_tag_b (src_tag_b),
        .old_tag   (old_tag)
    );

    // committed state, source of flush recovery
    arch_map u_arch_map (
        .clock       (clock),
        .reset       (reset),
        .retire_en   (retire_en),
        .retire_areg (retire_areg),
        .retire_tag  (retire_tag),
        .arch_tags   (arch_tags)
    );

endmodule

/* rename_core_tb.sv */
// one op per clock; a queue model predicts each row, head fields and dest_tag are checked only when defined
module rename_core_tb;

    // stimulus and predicted outputs for one clock
    typedef struct packed {
        logic                 disp;
        logic                 ret;
        logic                 fl;
        rename_pkg::areg_t    dest;
        rename_pkg::areg_t    src_a;
        rename_pkg::areg_t    src_b;
        logic                 stall;
        rename_pkg::preg_t    tag_a;
        rename_pkg::preg_t    tag_b;
        rename_pkg::preg_t    old;
        rename_pkg::preg_t    new_tag;
        logic                 dest_known;
        rename_pkg::rob_idx_t index;
        logic                 done;
        logic                 head_known;
        rename_pkg::areg_t    r_areg;
        rename_pkg::preg_t    r_tag;
        rename_pkg::preg_t    r_freed;
        logic                 empty;
    } row_t;

    logic clock;
    logic reset;
    logic dispatch_valid;
    logic retire_valid;
    logic flush;
    rename_pkg::areg_t dest_reg;
    rename_pkg::areg_t src_reg_a;
    rename_pkg::areg_t src_reg_b;
    logic stall;
    rename_pkg::preg_t src_tag_a;
    rename_pkg::preg_t src_tag_b;
    rename_pkg::preg_t dest_tag;
    rename_pkg::preg_t old_tag;
    rename_pkg::rob_idx_t rob_index;
    logic retire_done;
    rename_pkg::areg_t retire_areg;
    rename_pkg::preg_t retire_tag;
    rename_pkg::preg_t freed_tag;
    logic rob_empty;

    row_t rows [$];
    string names [$];
    int row_errors;
    int pass_count = 0;
    int fail_count = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    // model state: speculative and committed maps, free tags in pop order, rob entries
    rename_pkg::preg_t spec_map [rename_pkg::NUM_AREGS];
    rename_pkg::preg_t commit_map [rename_pkg::NUM_AREGS];
    rename_pkg::preg_t free_q [$];
    rename_pkg::areg_t rob_dest [$];
    rename_pkg::preg_t rob_new [$];
    rename_pkg::preg_t rob_old [$];
    int head_pos = 0;

    rename_core uut (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dest_reg       (dest_reg),
        .src_reg_a      (src_reg_a),
        .src_reg_b      (src_reg_b),
        .retire_valid   (retire_valid),
        .flush          (flush),
        .stall          (stall),
        .src_tag_a      (src_tag_a),
        .src_tag_b      (src_tag_b),
        .dest_tag       (dest_tag),
        .old_tag        (old_tag),
        .rob_index      (rob_index),
        .retire_done    (retire_done),
        .retire_areg    (retire_areg),
        .retire_tag     (retire_tag),
        .freed_tag      (freed_tag),
        .rob_empty      (rob_empty)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // predict one clock from the model state, then advance the model
    task automatic add_row(input string name, input logic disp, input logic ret, input logic fl,
                           input rename_pkg::areg_t dest, input rename_pkg::areg_t src_a,
                           input rename_pkg::areg_t src_b);
        row_t r;
        logic has_dest;
        r = '0;
        has_dest = (dest != rename_pkg::ZERO_AREG);
        r.disp = disp;
        r.ret = ret;
        r.fl = fl;
        r.dest = dest;
        r.src_a = src_a;
        r.src_b = src_b;
        r.stall = (rob_dest.size() == rename_pkg::ROB_SZ) || (has_dest && free_q.size() == 0);
        r.tag_a = (src_a == rename_pkg::ZERO_AREG) ? '0 : spec_map[src_a];
        r.tag_b = (src_b == rename_pkg::ZERO_AREG) ? '0 : spec_map[src_b];
        r.old = has_dest ? spec_map[dest] : '0;
        // front of an empty free list is undefined
        r.dest_known = !has_dest || (free_q.size() > 0);
        r.new_tag = (has_dest && free_q.size() > 0) ? free_q[0] : '0;
        r.index = rename_pkg::rob_idx_t'((head_pos + rob_dest.size()) % rename_pkg::ROB_SZ);
        r.empty = (rob_dest.size() == 0);
        r.head_known = !r.empty;
        if (!r.empty) begin
            r.r_areg = rob_dest[0];
            r.r_tag = rob_new[0];
            r.r_freed = rob_old[0];
        end
        r.done = ret && !r.empty && !fl;
        if (fl) begin
            // squashed tags rejoin ahead of the free ones, oldest first
            for (int i = rob_dest.size() - 1; i >= 0; i--) begin
                if (rob_dest[i] != rename_pkg::ZERO_AREG) begin
                    free_q.push_front(rob_new[i]);
                end
            end
            spec_map = commit_map;
            rob_dest.delete();
            rob_new.delete();
            rob_old.delete();
        end else begin
            if (r.done) begin
                if (rob_dest[0] != rename_pkg::ZERO_AREG) begin
                    free_q.push_back(rob_old[0]);
                    commit_map[rob_dest[0]] = rob_new[0];
                end
                void'(rob_dest.pop_front());
                void'(rob_new.pop_front());
                void'(rob_old.pop_front());
                head_pos = (head_pos + 1) % rename_pkg::ROB_SZ;
            end
            if (disp && !r.stall) begin
                if (has_dest) begin
                    void'(free_q.pop_front());
                    spec_map[dest] = r.new_tag;
                end
                rob_dest.push_back(dest);
                rob_new.push_back(r.new_tag);
                rob_old.push_back(r.old);
            end
        end
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic fill_table();
        for (int i = 0; i < rename_pkg::NUM_AREGS; i++) begin
            spec_map[i] = rename_pkg::preg_t'(i);
            commit_map[i] = rename_pkg::preg_t'(i);
            free_q.push_back(rename_pkg::preg_t'(rename_pkg::NUM_AREGS + i));
        end
        add_row("reset_idle", 1'b0, 1'b0, 1'b0, 3'd0, 3'd3, 3'd5);
        add_row("reset_first_dispatch", 1'b1, 1'b0, 1'b0, 3'd1, 3'd2, 3'd3);
        // r1 renamed three times in a row
        add_row("chain_second", 1'b1, 1'b0, 1'b0, 3'd1, 3'd1, 3'd0);
        add_row("chain_third", 1'b1, 1'b0, 1'b0, 3'd1, 3'd1, 3'd1);
        add_row("chain_read", 1'b0, 1'b0, 1'b0, 3'd0, 3'd1, 3'd2);
        add_row("zero_dispatch", 1'b1, 1'b0, 1'b0, 3'd0, 3'd1, 3'd2);
        add_row("zero_next_front", 1'b1, 1'b0, 1'b0, 3'd2, 3'd0, 3'd1);
        for (int k = 0; k < 5; k++) begin
            add_row($sformatf("retire_order_%0d", k), 1'b0, 1'b1, 1'b0, 3'd0, 3'd1, 3'd2);
        end
        // two r0 entries, so the rob fills before the free list does
        for (int k = 0; k < 8; k++) begin
            add_row($sformatf("fill_%0d", k), 1'b1, 1'b0, 1'b0,
                    (k % 4 == 1) ? 3'd0 : rename_pkg::areg_t'(k % 7 + 1),
                    rename_pkg::areg_t'(k), rename_pkg::areg_t'(7 - k));
        end
        add_row("full_stall", 1'b1, 1'b0, 1'b0, 3'd3, 3'd4, 3'd5);
        add_row("full_same_cycle_retire", 1'b1, 1'b1, 1'b0, 3'd3, 3'd4, 3'd5);
        add_row("full_after_retire", 1'b1, 1'b0, 1'b0, 3'd3, 3'd4, 3'd5);
        for (int k = 0; k < 8; k++) begin
            add_row($sformatf("drain_%0d", k), 1'b0, 1'b1, 1'b0, 3'd0, 3'd3, 3'd1);
        end
        // eight nonzero dispatches use up every free tag
        for (int k = 0; k < 8; k++) begin
            add_row($sformatf("free_drain_%0d", k), 1'b1, 1'b0, 1'b0,
                    rename_pkg::areg_t'(k % 7 + 1), rename_pkg::areg_t'(k), 3'd6);
        end
        add_row("free_empty_stall", 1'b1, 1'b0, 1'b0, 3'd6, 3'd2, 3'd4);
        for (int k = 0; k < 3; k++) begin
            add_row($sformatf("pre_flush_retire_%0d", k), 1'b0, 1'b1, 1'b0, 3'd0, 3'd1, 3'd2);
        end
        add_row("flush_wins", 1'b1, 1'b1, 1'b1, 3'd4, 3'd1, 3'd2);
        for (int k = 0; k < 4; k++) begin
            add_row($sformatf("post_flush_read_%0d", k), 1'b0, 1'b0, 1'b0, 3'd0,
                    rename_pkg::areg_t'(2 * k), rename_pkg::areg_t'(2 * k + 1));
        end
        add_row("post_flush_dispatch", 1'b1, 1'b0, 1'b0, 3'd5, 3'd5, 3'd6);
        // mixed traffic, mostly dispatch, occasional flush
        for (int k = 0; k < 60; k++) begin
            add_row($sformatf("random_%0d", k), ($urandom % 4) != 0, ($urandom % 2) != 0,
                    ($urandom % 20) == 0, rename_pkg::areg_t'($urandom % 8),
                    rename_pkg::areg_t'($urandom % 8), rename_pkg::areg_t'($urandom % 8));
        end
    endtask

    task automatic check_tag(input string name, input string what,
                             input rename_pkg::preg_t expected, input rename_pkg::preg_t actual);
        if (actual !== expected) begin
            $display("Error %s %s: expected %0d, actual %0d", name, what, expected, actual);
            row_errors++;
        end
    endtask

    // also used for rob_index, same 3-bit vector
    task automatic check_reg(input string name, input string what,
                             input rename_pkg::areg_t expected, input rename_pkg::areg_t actual);
        if (actual !== expected) begin
            $display("Error %s %s: expected %0d, actual %0d", name, what, expected, actual);
            row_errors++;
        end
    endtask

    task automatic check_bit(input string name, input string what,
                             input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error %s %s: expected %b, actual %b", name, what, expected, actual);
            row_errors++;
        end
    endtask

    task automatic check_row(input int i);
        row_t r;
        r = rows[i];
        check_bit(names[i], "stall", r.stall, stall);
        check_tag(names[i], "src_tag_a", r.tag_a, src_tag_a);
        check_tag(names[i], "src_tag_b", r.tag_b, src_tag_b);
        check_tag(names[i], "old_tag", r.old, old_tag);
        if (r.dest_known) begin
            check_tag(names[i], "dest_tag", r.new_tag, dest_tag);
        end
        check_reg(names[i], "rob_index", r.index, rob_index);
        check_bit(names[i], "retire_done", r.done, retire_done);
        if (r.head_known) begin
            check_reg(names[i], "retire_areg", r.r_areg, retire_areg);
            check_tag(names[i], "retire_tag", r.r_tag, retire_tag);
            check_tag(names[i], "freed_tag", r.r_freed, freed_tag);
        end
        check_bit(names[i], "rob_empty", r.empty, rob_empty);
    endtask

    // watchdog, limit set once the table length is known
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout: the run went past %0d clock cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        dispatch_valid = 1'b0;
        retire_valid = 1'b0;
        flush = 1'b0;
        dest_reg = '0;
        src_reg_a = '0;
        src_reg_b = '0;
        void'($urandom(32'h719fe3a4));
        fill_table();
        cycle_limit = rows.size() + 5 + 20;
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            dispatch_valid = rows[i].disp;
            retire_valid = rows[i].ret;
            flush = rows[i].fl;
            dest_reg = rows[i].dest;
            src_reg_a = rows[i].src_a;
            src_reg_b = rows[i].src_b;
            // sample just before the next rising edge
            #6;
            row_errors = 0;
            check_row(i);
            if (row_errors == 0) begin
                pass_count++;
                $display("row %0d %s ok", i, names[i]);
            end else begin
                fail_count++;
                $display("row %0d %s had %0d mismatches", i, names[i], row_errors);
            end
            @(posedge clock);
            #1;
        end
        $display("%0d rows passed, %0d rows failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* rename_pkg.sv */
// fixed sizes for the whole rename subsystem; one dispatch per cycle, tags are 4 bits, reset maps areg i to tag i
package rename_pkg;

    // architectural register file size
    localparam int NUM_AREGS = 8;
    // physical register file size
    localparam int NUM_PREGS = 16;
    // reorder buffer depth
    localparam int ROB_SZ = 8;
    // free list only ever holds the tags not in the committed map
    localparam int FREE_SZ = NUM_PREGS - NUM_AREGS;

    typedef logic [$clog2(NUM_AREGS)-1:0] areg_t;
    typedef logic [$clog2(NUM_PREGS)-1:0] preg_t;
    typedef logic [$clog2(ROB_SZ)-1:0] rob_idx_t;
    // extra msb is the wrap bit, so full and empty differ
    typedef logic [$clog2(ROB_SZ):0] rob_ptr_t;
    typedef logic [$clog2(FREE_SZ):0] free_ptr_t;

    // r0 is hardwired, never renamed
    localparam areg_t ZERO_AREG = '0;

    // identity mapping after reset
    function automatic preg_t reset_map_tag(input int unsigned areg);
        return preg_t'(areg);
    endfunction

    // slot i of the free list starts with tag NUM_AREGS + i
    function automatic preg_t reset_free_tag(input int unsigned slot);
        return preg_t'(NUM_AREGS + slot);
    endfunction

    // storage slot addressed by a free list pointer, wrap bit dropped
    function automatic int unsigned free_slot(input free_ptr_t ptr);
        return int'(ptr) % FREE_SZ;
    endfunction

    // storage slot addressed by a rob pointer, wrap bit dropped
    function automatic rob_idx_t rob_slot(input rob_ptr_t ptr);
        return rob_idx_t'(ptr);
    endfunction

endpackage

/* reorder_buffer.sv */
// in-order rob with single dispatch and single retire per cycle; flush empties it, no partial rollback
module reorder_buffer (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 dispatch_valid,
    input  logic                 flush,
    input  logic                 retire_valid,
    input  rename_pkg::areg_t    dest_reg,
    input  rename_pkg::preg_t    new_tag,
    input  rename_pkg::preg_t    old_tag_in,
    input  logic                 free_empty,
    output logic                 stall,
    output logic                 alloc_en,
    output logic                 retire_en,
    output rename_pkg::rob_idx_t rob_index,
    output rename_pkg::areg_t    retire_areg,
    output rename_pkg::preg_t    retire_tag,
    output rename_pkg::preg_t    freed_tag,
    output logic                 rob_empty
);

    // per-entry payload held between head and tail
    rename_pkg::areg_t entry_dest [rename_pkg::ROB_SZ];
    rename_pkg::preg_t entry_tag [rename_pkg::ROB_SZ];
    rename_pkg::preg_t entry_old [rename_pkg::ROB_SZ];

    // pointers carry a wrap bit above the index
    rename_pkg::rob_ptr_t head;
    rename_pkg::rob_ptr_t tail;

    logic rob_full;
    logic need_tag;
    rename_pkg::rob_idx_t head_slot;
    rename_pkg::rob_idx_t tail_slot;

    assign head_slot = rename_pkg::rob_slot(head);
    assign tail_slot = rename_pkg::rob_slot(tail);

    // full means same index with opposite wrap bit
    assign rob_full = (tail == (head ^ rename_pkg::rob_ptr_t'(rename_pkg::ROB_SZ)));
    assign rob_empty = (head == tail);

    // r0 destinations do not consume a free tag
    assign need_tag = (dest_reg != rename_pkg::ZERO_AREG);

    // built from registered state only, so a same-cycle retire
    // on a full buffer does not lower it
    assign stall = rob_full || (need_tag && free_empty);

    // flush wins over both dispatch and retire
    assign alloc_en = dispatch_valid && !stall && !flush;
    assign retire_en = retire_valid && !rob_empty && !flush;

    // index handed back to dispatch for this instruction
    assign rob_index = tail_slot;

    // head entry fields are valid whenever the buffer is not empty
    assign retire_areg = entry_dest[head_slot];
    assign retire_tag = entry_tag[head_slot];
    assign freed_tag = entry_old[head_slot];

    // payload write at the tail
    always_ff @(posedge clock) begin
        if (alloc_en) begin
            entry_dest[tail_slot] <= dest_reg;
            // free list front already reads 0 for r0
            entry_tag[tail_slot] <= new_tag;
            // map table returns 0 as the old tag of r0
            entry_old[tail_slot] <= old_tag_in;
        end
    end

    // pointer control
    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
        end else if (flush) begin
            // everything in flight is squashed
            tail <= head;
        end else begin
            if (alloc_en) begin
                tail <= tail + rename_pkg::rob_ptr_t'(1);
            end
            if (retire_en) begin
                head <= head + rename_pkg::rob_ptr_t'(1);
            end
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the rename core testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f flist.f --top-module rename_core_tb -Mdir obj_dir -o rename_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/rename_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1
